// File: design/eeprom_proto_pkg.sv
package eeprom_proto_pkg;

    // byte address into the 2 KB array
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // fixed device type code, first nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // upper address bits carried inside the control byte
    localparam int HI_ADDR_W = 3;

    // r/w bit at the end of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // quarter phases of one bit time
    // scl is low in the first two and high in the last two
    typedef enum logic [1:0]
    {
        LOW_SETUP,   // sda may change here
        RISE,        // scl still low, rises at the end
        HIGH_SAMPLE, // scl high, data settling
        FALL         // scl high, falls at the end
    } bit_phase_e;

endpackage

// File: design/ctrl_pkg.sv
package ctrl_pkg;

    // commands from the sequencer to the line serializer
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE_BYTE,
        CMD_READ_BYTE
    } line_cmd_e;

    typedef enum logic [3:0]
    {
        IDLE,
        WR_START,
        WR_CTRL,
        WR_ADDR,
        WR_DATA,
        RD_RESTART,
        RD_CTRL,
        RD_DATA,
        STOP,
        ACKN
    } seq_state_e;

endpackage

// File: design/line_serializer.sv
`timescale 1ns/10ps
module line_serializer
    import eeprom_proto_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int SCL_QUARTER = 2
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_go,
    input  line_cmd_e         cmd,
    input  logic [DATA_W-1:0] tx_byte,
    output logic              scl,
    output logic              sda_out,
    output logic              sda_oe,
    output logic              sample_tick,
    output logic              line_done
);

    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;
    localparam int BW = $clog2(DATA_W);
    localparam logic [QW-1:0] QMAX = QW'(SCL_QUARTER - 1);

    logic              busy;
    logic              bus_free;  // no start outstanding
    line_cmd_e         cmd_q;
    bit_phase_e        phase;
    logic [QW-1:0]     qcnt;
    logic [BW-1:0]     bitcnt;
    logic [DATA_W-1:0] shreg;
    logic              last_bit;
    bit_phase_e        next_phase;

    // line levels {scl, sda} for a given quarter of a command
    function automatic logic [1:0] line_level(input line_cmd_e c, input bit_phase_e p,
                                              input logic b, input logic free);
        logic [1:0] lv;
        case (c)
            CMD_START:
                case (p)
                    LOW_SETUP:   lv = {free, 1'b1}; // scl low first on a restart
                    RISE:        lv = 2'b11;
                    HIGH_SAMPLE: lv = 2'b10;        // sda falls with scl high
                    default:     lv = 2'b00;
                endcase
            CMD_STOP:
                case (p)
                    LOW_SETUP:   lv = 2'b00;
                    RISE:        lv = 2'b10;
                    default:     lv = 2'b11;        // sda rises with scl high
                endcase
            default:
                lv = {(p == HIGH_SAMPLE || p == FALL), b};
        endcase
        return lv;
    endfunction

    assign last_bit   = (cmd_q == CMD_START) || (cmd_q == CMD_STOP) || (bitcnt == BW'(DATA_W - 1));
    assign next_phase = bit_phase_e'(phase + 2'd1);

    always_ff @(posedge CLK)
    begin
        line_done   <= 1'b0;
        sample_tick <= 1'b0;
        if (RESET)
        begin
            busy     <= 1'b0;
            bus_free <= 1'b1;
            cmd_q    <= CMD_START;
            phase    <= LOW_SETUP;
            qcnt     <= '0;
            bitcnt   <= '0;
            scl      <= 1'b1;
            sda_out  <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else if (!busy)
        begin
            if (cmd_go)
            begin
                busy   <= 1'b1;
                cmd_q  <= cmd;
                shreg  <= tx_byte;
                phase  <= LOW_SETUP;
                qcnt   <= '0;
                bitcnt <= '0;
                {scl, sda_out} <= line_level(cmd, LOW_SETUP, tx_byte[DATA_W-1], bus_free);
                sda_oe <= (cmd != CMD_READ_BYTE);
            end
        end
        else if (qcnt != QMAX)
            qcnt <= qcnt + 1'b1;
        else
        begin
            qcnt <= '0;
            if (phase != FALL)
            begin
                phase <= next_phase;
                {scl, sda_out} <= line_level(cmd_q, next_phase, shreg[DATA_W-1], bus_free);
                // lands in the first cycle of the second high quarter
                if (cmd_q == CMD_READ_BYTE && phase == HIGH_SAMPLE)
                    sample_tick <= 1'b1;
            end
            else if (last_bit)
            begin
                busy      <= 1'b0;
                line_done <= 1'b1;
                phase     <= LOW_SETUP;
                if (cmd_q == CMD_START)
                    bus_free <= 1'b0;
                if (cmd_q == CMD_STOP)
                begin
                    bus_free <= 1'b1;
                    sda_oe   <= 1'b0; // sda already high, just let go
                end
            end
            else
            begin
                phase  <= LOW_SETUP;
                bitcnt <= bitcnt + 1'b1;
                shreg  <= {shreg[DATA_W-2:0], 1'b0};
                {scl, sda_out} <= line_level(cmd_q, LOW_SETUP, shreg[DATA_W-2], bus_free);
            end
        end
    end

endmodule

// File: design/byte_deserializer.sv
`timescale 1ns/10ps
module byte_deserializer
    import eeprom_proto_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              rx_start,
    input  logic              sample_tick,
    input  logic              sda_in,
    output logic [DATA_W-1:0] rx_byte,
    output logic              rx_done
);

    localparam int BW = $clog2(DATA_W);

    logic          armed;
    logic [BW-1:0] bitcnt;

    // arming and bit count
    always_ff @(posedge CLK)
    begin
        rx_done <= 1'b0;
        if (RESET)
        begin
            armed  <= 1'b0;
            bitcnt <= '0;
        end
        else if (rx_start)
        begin
            armed  <= 1'b1;
            bitcnt <= '0;
        end
        else if (armed && sample_tick)
        begin
            bitcnt <= bitcnt + 1'b1;
            if (bitcnt == BW'(DATA_W - 1))
            begin
                armed   <= 1'b0; // byte complete
                rx_done <= 1'b1;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge CLK)
    begin
        if (armed && sample_tick && !rx_start)
            rx_byte <= {rx_byte[DATA_W-2:0], sda_in};
    end

endmodule

// File: design/transfer_sequencer.sv
`timescale 1ns/10ps
module transfer_sequencer
    import eeprom_proto_pkg::*;
    import ctrl_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] data_in,
    input  logic              line_done,
    input  logic              rx_done,
    input  logic [DATA_W-1:0] rx_byte,
    output logic              cmd_go,
    output line_cmd_e         cmd,
    output logic [DATA_W-1:0] tx_byte,
    output logic              rx_start,
    output logic              ack,
    output logic [DATA_W-1:0] data_out
);

    seq_state_e        state;
    logic              is_read;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic              line_seen; // read byte: line side finished
    logic              rx_seen;   // read byte: deserializer finished
    logic              rd_complete;

    function automatic logic [DATA_W-1:0] ctrl_byte(input logic [ADDR_W-1:0] a,
                                                    input logic rw);
        return {DEV_CODE, a[ADDR_W-1 -: HI_ADDR_W], rw};
    endfunction

    assign rd_complete = (line_seen || line_done) && (rx_seen || rx_done);

    // request latch, payload only
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= data_in;
        end
    end

    always_ff @(posedge CLK)
    begin
        cmd_go   <= 1'b0;
        rx_start <= 1'b0;
        ack      <= 1'b0;
        if (RESET)
        begin
            state     <= IDLE;
            is_read   <= 1'b0;
            cmd       <= CMD_START;
            line_seen <= 1'b0;
            rx_seen   <= 1'b0;
            data_out  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (wr || rd)
                    begin
                        is_read <= !wr; // wr wins a tie
                        cmd_go  <= 1'b1;
                        cmd     <= CMD_START;
                        state   <= WR_START;
                    end
                WR_START:
                    if (line_done)
                    begin
                        cmd_go  <= 1'b1;
                        cmd     <= CMD_WRITE_BYTE;
                        tx_byte <= ctrl_byte(addr_q, RW_WRITE);
                        state   <= WR_CTRL;
                    end
                WR_CTRL:
                    if (line_done)
                    begin
                        cmd_go  <= 1'b1;
                        cmd     <= CMD_WRITE_BYTE;
                        tx_byte <= addr_q[DATA_W-1:0];
                        state   <= WR_ADDR;
                    end
                WR_ADDR:
                    if (line_done)
                    begin
                        cmd_go <= 1'b1;
                        if (is_read)
                        begin
                            cmd   <= CMD_START; // repeated start
                            state <= RD_RESTART;
                        end
                        else
                        begin
                            cmd     <= CMD_WRITE_BYTE;
                            tx_byte <= data_q;
                            state   <= WR_DATA;
                        end
                    end
                WR_DATA:
                    if (line_done)
                    begin
                        cmd_go <= 1'b1;
                        cmd    <= CMD_STOP;
                        state  <= STOP;
                    end
                RD_RESTART:
                    if (line_done)
                    begin
                        cmd_go  <= 1'b1;
                        cmd     <= CMD_WRITE_BYTE;
                        tx_byte <= ctrl_byte(addr_q, RW_READ);
                        state   <= RD_CTRL;
                    end
                RD_CTRL:
                    if (line_done)
                    begin
                        cmd_go    <= 1'b1;
                        cmd       <= CMD_READ_BYTE;
                        rx_start  <= 1'b1;
                        line_seen <= 1'b0;
                        rx_seen   <= 1'b0;
                        state     <= RD_DATA;
                    end
                RD_DATA:
                begin
                    if (line_done)
                        line_seen <= 1'b1;
                    if (rx_done)
                    begin
                        rx_seen  <= 1'b1;
                        data_out <= rx_byte;
                    end
                    if (rd_complete)
                    begin
                        cmd_go <= 1'b1;
                        cmd    <= CMD_STOP;
                        state  <= STOP;
                    end
                end
                STOP:
                    if (line_done)
                    begin
                        ack   <= 1'b1;
                        state <= ACKN;
                    end
                ACKN:
                    state <= IDLE; // ack drops here
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/eeprom_ctrl.sv
`timescale 1ns/10ps
module eeprom_ctrl
    import eeprom_proto_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int SCL_QUARTER = 2
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] data_in,
    input  logic              sda_in,
    output logic              ack,
    output logic [DATA_W-1:0] data_out,
    output logic              scl,
    output logic              sda_out,
    output logic              sda_oe
);

    logic              cmd_go;
    line_cmd_e         cmd;
    logic [DATA_W-1:0] tx_byte;
    logic              line_done;
    logic              sample_tick;
    logic              rx_start;
    logic              rx_done;
    logic [DATA_W-1:0] rx_byte;

    transfer_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .data_in   (data_in),
        .line_done (line_done),
        .rx_done   (rx_done),
        .rx_byte   (rx_byte),
        .cmd_go    (cmd_go),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .rx_start  (rx_start),
        .ack       (ack),
        .data_out  (data_out)
    );

    line_serializer #(.SCL_QUARTER(SCL_QUARTER)) u_ser
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_go      (cmd_go),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe),
        .sample_tick (sample_tick),
        .line_done   (line_done)
    );

    // captures sda alongside the serializer during a read byte
    byte_deserializer u_des
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .rx_start    (rx_start),
        .sample_tick (sample_tick),
        .sda_in      (sda_in),
        .rx_byte     (rx_byte),
        .rx_done     (rx_done)
    );

endmodule

// File: verif/eeprom_model.sv
`timescale 1ns/10ps
module eeprom_model
(
    input  logic       scl,
    input  logic       sda,
    output logic       sda_pull,
    output logic [7:0] last_ctrl,
    output logic [7:0] wr_ctrl,
    output int         n_start,
    output int         n_stop,
    output int         n_bits,
    output logic       in_xfer
);

    localparam int ST_CTRL = 0;
    localparam int ST_ADDR = 1;
    localparam int ST_DATA = 2;
    localparam int ST_READ = 3;
    localparam int ST_DONE = 4;

    logic [7:0]  mem [2048];
    logic [7:0]  shreg;
    logic [2:0]  hi;
    logic [10:0] ptr;
    int          stage;
    int          bitcnt;
    int          rcnt;
    logic        scl_q;
    logic        sda_q;

    // one process decodes the whole bus
    initial
    begin
        int i;
        for (i = 0; i < 2048; i++)
            mem[i] = 8'(i * 29) ^ 8'(i >> 3);
        sda_pull  = 1'b0;
        last_ctrl = 8'h00;
        wr_ctrl   = 8'h00;
        n_start   = 0;
        n_stop    = 0;
        n_bits    = 0;
        in_xfer   = 1'b0;
        shreg     = 8'h00;
        hi        = 3'd0;
        ptr       = 11'd0;
        stage     = ST_DONE;
        bitcnt    = 0;
        rcnt      = 0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl_q && scl && sda_q && !sda)
            begin
                if (!in_xfer) // a fresh transfer clears the counters
                begin
                    n_start   = 0;
                    n_stop    = 0;
                    n_bits    = 0;
                    last_ctrl = 8'h00;
                    wr_ctrl   = 8'h00;
                end
                else
                    n_bits--; // the rise before a restart carries no bit
                in_xfer  = 1'b1;
                n_start++;
                stage    = ST_CTRL;
                bitcnt   = 0;
                sda_pull = 1'b0;
            end
            else if (scl_q && scl && !sda_q && sda)
            begin
                if (in_xfer)
                    n_bits--; // the rise before a stop carries no bit
                n_stop++;
                in_xfer  = 1'b0;
                stage    = ST_DONE;
                sda_pull = 1'b0;
            end
            else if (!scl_q && scl && in_xfer)
            begin
                n_bits++;
                if (stage == ST_READ)
                    rcnt++; // host samples our bit here
                else
                begin
                    shreg = {shreg[6:0], sda};
                    bitcnt++;
                    if (bitcnt == 8)
                    begin
                        bitcnt = 0;
                        case (stage)
                            ST_CTRL:
                            begin
                                last_ctrl = shreg;
                                hi        = shreg[3:1];
                                if (shreg[0])
                                begin
                                    stage = ST_READ;
                                    rcnt  = 0;
                                end
                                else
                                begin
                                    wr_ctrl = shreg;
                                    stage   = ST_ADDR;
                                end
                            end
                            ST_ADDR:
                            begin
                                ptr   = {hi, shreg};
                                stage = ST_DATA;
                            end
                            ST_DATA:
                            begin
                                mem[ptr] = shreg;
                                stage    = ST_DONE;
                            end
                            default:
                                stage = ST_DONE;
                        endcase
                    end
                end
            end
            else if (scl_q && !scl && stage == ST_READ)
            begin
                // next read bit while scl is low
                if (rcnt < 8)
                    sda_pull = !mem[ptr][3'(7 - rcnt)];
                else
                begin
                    sda_pull = 1'b0;
                    stage    = ST_DONE;
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// File: verif/tb_eeprom_ctrl.sv
`timescale 1ns/10ps
module tb_eeprom_ctrl;

    localparam int SCL_QUARTER = 2;
    localparam int MEM_SIZE    = 2048;
    localparam int ACK_TIMEOUT = 200 * SCL_QUARTER + 50;
    localparam int RUN_LIMIT   = 200000;
    localparam int RANDOM_OPS  = 40;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  data_in;
    logic        ack;
    logic [7:0]  data_out;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_pull;
    wire         sda;

    logic [7:0]  last_ctrl;
    logic [7:0]  wr_ctrl;
    int          n_start;
    int          n_stop;
    int          n_bits;
    logic        in_xfer;

    logic [7:0]  sb [MEM_SIZE];
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          ack_pending;
    bit          exp_read;
    logic [10:0] exp_addr;
    logic [7:0]  exp_data;

    // open drain line with pull-up
    assign sda = !((sda_oe && !sda_out) || sda_pull);

    eeprom_ctrl #(.SCL_QUARTER(SCL_QUARTER)) dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .sda_in   (sda),
        .ack      (ack),
        .data_out (data_out),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe)
    );

    eeprom_model model
    (
        .scl       (scl),
        .sda       (sda),
        .sda_pull  (sda_pull),
        .last_ctrl (last_ctrl),
        .wr_ctrl   (wr_ctrl),
        .n_start   (n_start),
        .n_stop    (n_stop),
        .n_bits    (n_bits),
        .in_xfer   (in_xfer)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // checks sample on the falling edge, away from all updates
    bus_idle: assert property (@(negedge CLK) disable iff (RESET)
        !ack_pending |-> (!ack && scl && !sda_oe))
    else
    begin
        $display("%0t: bus active or ack seen with no request pending", $time);
        errors = errors + 1;
    end

    ack_single_cycle: assert property (@(negedge CLK) disable iff (RESET) ack |=> !ack)
    else
    begin
        $display("%0t: ack stayed high for more than one cycle", $time);
        errors = errors + 1;
    end

    read_data: assert property (@(negedge CLK) disable iff (RESET)
        (ack && exp_read) |-> (data_out == exp_data))
    else
    begin
        $display("Mismatch at %0t: data_out expected %02h actual %02h",
                 $time, exp_data, data_out);
        errors = errors + 1;
    end

    last_ctrl_byte: assert property (@(negedge CLK) disable iff (RESET)
        ack |-> (last_ctrl == {4'b1010, exp_addr[10:8], exp_read}))
    else
    begin
        $display("Mismatch at %0t: last_ctrl expected %02h actual %02h",
                 $time, {4'b1010, exp_addr[10:8], exp_read}, last_ctrl);
        errors = errors + 1;
    end

    write_ctrl_byte: assert property (@(negedge CLK) disable iff (RESET)
        ack |-> (wr_ctrl == {4'b1010, exp_addr[10:8], 1'b0}))
    else
    begin
        $display("Mismatch at %0t: wr_ctrl expected %02h actual %02h",
                 $time, {4'b1010, exp_addr[10:8], 1'b0}, wr_ctrl);
        errors = errors + 1;
    end

    start_count: assert property (@(negedge CLK) disable iff (RESET)
        ack |-> (n_start == (exp_read ? 2 : 1)))
    else
    begin
        $display("Mismatch at %0t: n_start expected %0d actual %0d",
                 $time, exp_read ? 2 : 1, n_start);
        errors = errors + 1;
    end

    bit_count: assert property (@(negedge CLK) disable iff (RESET)
        ack |-> (n_bits == (exp_read ? 32 : 24)))
    else
    begin
        $display("Mismatch at %0t: n_bits expected %0d actual %0d",
                 $time, exp_read ? 32 : 24, n_bits);
        errors = errors + 1;
    end

    stop_before_ack: assert property (@(negedge CLK) disable iff (RESET)
        ack |-> (n_stop == 1 && !in_xfer))
    else
    begin
        $display("%0t: transfer not closed by a single stop before ack", $time);
        errors = errors + 1;
    end

    // with scl high sda may only move at a byte boundary (start or stop)
    sda_stable_high: assert property (@(negedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda != $past(sda))) |-> (n_bits % 8 == 0))
    else
    begin
        $display("%0t: sda changed with scl high inside a byte", $time);
        errors = errors + 1;
    end

    // called right after a rising edge
    task automatic drive_strobe(input bit w, input bit r, input logic [10:0] a,
                                input logic [7:0] d);
        wr      <= w;
        rd      <= r;
        addr    <= a;
        data_in <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic request(input bit w, input bit r, input logic [10:0] a,
                           input logic [7:0] d);
        @(posedge CLK);
        ack_pending = 1'b1;
        exp_read    = !w; // wr wins a tie
        exp_addr    = a;
        exp_data    = sb[a];
        if (w)
            sb[a] = d;
        drive_strobe(w, r, a, d);
    endtask

    task automatic busy_strobe(input bit w, input bit r, input logic [10:0] a,
                               input logic [7:0] d);
        @(posedge CLK);
        drive_strobe(w, r, a, d);
    endtask

    task automatic wait_ack();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            seen = ack;
            n    = n + 1;
        end
        if (!seen)
        begin
            $display("%0t: no ack within %0d cycles", $time, ACK_TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            @(posedge CLK);
            ack_pending = 1'b0;
        end
    endtask

    task automatic write_then_read(input logic [10:0] a, input logic [7:0] d);
        request(1'b1, 1'b0, a, d);
        wait_ack();
        request(1'b0, 1'b1, a, 8'h00);
        wait_ack();
    endtask

    task automatic compare_memory();
        int i;
        for (i = 0; i < MEM_SIZE; i++)
        begin
            assert (model.mem[i] == sb[i])
            else
            begin
                $display("Mismatch at %0t: mem[%03h] expected %02h actual %02h",
                         $time, i, sb[i], model.mem[i]);
                errors = errors + 1;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (errors == err_before)
            $display("test %s: ok", name);
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial
    begin
        repeat (RUN_LIMIT) @(posedge CLK);
        $display("run limit of %0d cycles reached", RUN_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        int          err0;
        int          i;
        logic [10:0] a;
        logic [7:0]  d;
        bit          op;

        void'($urandom(32'h086ed978));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ack_pending  = 1'b0;
        exp_read     = 1'b0;
        exp_addr     = 11'd0;
        exp_data     = 8'h00;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = 11'd0;
        data_in      = 8'h00;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        for (i = 0; i < MEM_SIZE; i++)
            sb[i] = model.mem[i]; // power-up contents

        err0 = errors;
        repeat (20) @(posedge CLK);
        report_test("reset", err0);

        err0 = errors;
        write_then_read(11'($urandom), 8'($urandom));
        report_test("write_read", err0);

        err0 = errors;
        for (i = 0; i < 8; i++)
            write_then_read({3'(i), 8'($urandom)}, 8'($urandom));
        report_test("control_byte", err0);

        // alternating bit patterns stress the sda timing
        err0 = errors;
        write_then_read(11'h555, 8'haa);
        write_then_read(11'h2aa, 8'h55);
        report_test("bus_rule", err0);

        err0 = errors;
        a = 11'($urandom);
        d = 8'($urandom);
        request(1'b1, 1'b0, a, d);
        repeat (4) @(posedge CLK);
        busy_strobe(1'b1, 1'b0, ~a, ~d);
        busy_strobe(1'b0, 1'b1, a + 11'd1, 8'h00);
        busy_strobe(1'b1, 1'b1, a ^ 11'h100, d + 8'd1);
        wait_ack();
        repeat (2 * ACK_TIMEOUT) @(posedge CLK); // a late ack would show here
        compare_memory();
        a = 11'($urandom);
        d = 8'($urandom);
        request(1'b1, 1'b1, a, d);
        wait_ack();
        request(1'b0, 1'b1, a, 8'h00);
        wait_ack();
        compare_memory();
        report_test("busy_requests", err0);

        err0 = errors;
        for (i = 0; i < RANDOM_OPS; i++)
        begin
            a  = 11'($urandom);
            d  = 8'($urandom);
            op = 1'($urandom);
            request(op, !op, a, d);
            wait_ack();
        end
        compare_memory();
        report_test("random_run", err0);

        $display("tests %0d, failing tests %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
design/eeprom_proto_pkg.sv
design/ctrl_pkg.sv
design/line_serializer.sv
design/byte_deserializer.sv
design/transfer_sequencer.sv
design/eeprom_ctrl.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

// File: Makefile
# Verilator build and run for the EEPROM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
SIM       ?= $(OBJ_DIR)/V$(TOP)
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the pass line in the simulator output
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
